// ==== rtl/forth_pkg.sv ====
`default_nettype none

package forth_pkg;

  ////////////////////
  // widths
  ////////////////////

  // data stack entries and program words
  typedef logic [31:0] word_t;
  typedef logic [7:0]  prog_addr_t;
  typedef logic [3:0]  stack_ptr_t;
  // one serial character
  typedef logic [7:0]  byte_t;

  ////////////////////
  // sizes
  ////////////////////

  localparam int unsigned stack_depth = 16;
  localparam int unsigned prog_depth  = 256;
  localparam int unsigned led_count   = 3;

  // forth true flag, all bits set
  localparam word_t true_word = '1;

  ////////////////////
  // serial timing
  ////////////////////

  localparam int unsigned clks_per_bit = 625;
  localparam int unsigned bit_timer_w  = $clog2(clks_per_bit);

  ////////////////////
  // encodings
  ////////////////////

  // tokens in program memory, numbered 0 to 15
  typedef enum logic [31:0] {
    op_nop, op_lit, op_dup, op_drop, op_over, op_plus, op_minus, op_and,
    op_or, op_equal, op_zero_equal, op_branch, op_zero_branch, op_io_led,
    op_io_button, op_emit
  } op_e;

  // commands from the interpreter to the stack
  typedef enum logic [2:0] {
    cmd_none, cmd_push, cmd_pop, cmd_dup, cmd_over, cmd_binary, cmd_replace
  } stack_cmd_e;

  typedef enum logic [2:0] {
    alu_plus, alu_minus, alu_and, alu_or, alu_equal, alu_zero_equal
  } alu_op_e;

endpackage

`default_nettype wire

// ==== rtl/stack_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// command path from the interpreter into the data stack
interface stack_if import forth_pkg::*; ();

  stack_cmd_e cmd;
  alu_op_e    alu_op;
  word_t      push_value;
  // top and next on stack, always valid
  word_t      tos;
  word_t      nos;

  modport interp (output cmd, output alu_op, output push_value, input tos, input nos);
  modport stack (input cmd, input alu_op, input push_value, output tos, output nos);

endinterface

`default_nettype wire

// ==== rtl/program_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module program_ram import forth_pkg::*; (
  input  logic       clk,
  input  logic       we,
  input  prog_addr_t waddr,
  input  word_t      wdata,
  input  prog_addr_t raddr,
  output word_t      rdata
);

  // token storage, filled through the load port
  word_t mem [prog_depth];

  ////////////////////
  // load port
  ////////////////////

  // writes go in whenever we is high, reset or not
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  ////////////////////
  // fetch port
  ////////////////////

  // one cycle from raddr to rdata
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== rtl/data_stack.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_stack import forth_pkg::*; (
  input logic    clk,
  input logic    reset,
  stack_if.stack stk
);

  // circular storage, sp points at the top entry
  word_t      entries [stack_depth];
  stack_ptr_t sp;
  stack_ptr_t sp_up;
  stack_ptr_t sp_down;
  word_t      alu_result;

  // wraps both ways, no overflow check
  assign sp_up   = sp + stack_ptr_t'(1);
  assign sp_down = sp - stack_ptr_t'(1);

  assign stk.tos = entries[sp];
  assign stk.nos = entries[sp_down];

  ////////////////////
  // alu
  ////////////////////

  always_comb begin
    case (stk.alu_op)
      alu_plus:       alu_result = stk.nos + stk.tos;
      // second minus top, as in forth
      alu_minus:      alu_result = stk.nos - stk.tos;
      alu_and:        alu_result = stk.nos & stk.tos;
      alu_or:         alu_result = stk.nos | stk.tos;
      alu_equal:      alu_result = (stk.nos == stk.tos) ? true_word : '0;
      alu_zero_equal: alu_result = (stk.tos == '0) ? true_word : '0;
      default:        alu_result = '0;
    endcase
  end

  ////////////////////
  // stack update
  ////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      sp <= '0;
      for (int i = 0; i < stack_depth; i++) begin
        entries[i] <= '0;
      end
    end else begin
      case (stk.cmd)
        cmd_push: begin
          entries[sp_up] <= stk.push_value;
          sp             <= sp_up;
        end
        cmd_pop: begin
          sp <= sp_down;
        end
        cmd_dup: begin
          entries[sp_up] <= stk.tos;
          sp             <= sp_up;
        end
        cmd_over: begin
          entries[sp_up] <= stk.nos;
          sp             <= sp_up;
        end
        cmd_binary: begin
          // zero-equal only looks at the top, so depth stays
          if (stk.alu_op == alu_zero_equal) begin
            entries[sp] <= alu_result;
          end else begin
            entries[sp_down] <= alu_result;
            sp               <= sp_down;
          end
        end
        cmd_replace: begin
          entries[sp] <= stk.push_value;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/inner_interpreter.sv ====
`timescale 1ns/10ps
`default_nettype none

module inner_interpreter import forth_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  stack_if.interp    stk,
  output prog_addr_t rom_addr,
  input  word_t      rom_data,
  input  logic       button0,
  input  logic       button1,
  output logic       led_g,
  output logic       led_b,
  output logic       led_r,
  output logic       tx_req,
  input  logic       tx_ack,
  output byte_t      tx_byte
);

  typedef enum logic [1:0] {
    st_fetch, st_execute, st_operand, st_emit
  } state_e;

  state_e     state;
  prog_addr_t pc;
  op_e        op;
  // second cycle of st_operand, operand word on rom_data
  logic       operand_ready;
  logic       is_lit;
  logic       take_branch;
  logic [led_count-1:0] led_q;
  logic [1:0] btn_meta;
  logic [1:0] btn_sync;

  // pc feeds the program memory directly
  assign rom_addr = pc;

  // out of range words run as nop
  assign op = (rom_data[31:4] == '0) ? op_e'(rom_data) : op_nop;

  // pins are active low, led_q already holds the inverted bits
  assign led_g = led_q[0];
  assign led_b = led_q[1];
  assign led_r = led_q[2];

  ////////////////////
  // token decode
  ////////////////////

  always_comb begin
    stk.cmd        = cmd_none;
    stk.alu_op     = alu_plus;
    stk.push_value = rom_data;
    if (state == st_execute) begin
      case (op)
        op_dup:  stk.cmd = cmd_dup;
        op_over: stk.cmd = cmd_over;
        // zero branch and emit consume the top here
        op_drop, op_zero_branch, op_emit: stk.cmd = cmd_pop;
        op_plus: begin
          stk.cmd    = cmd_binary;
          stk.alu_op = alu_plus;
        end
        op_minus: begin
          stk.cmd    = cmd_binary;
          stk.alu_op = alu_minus;
        end
        op_and: begin
          stk.cmd    = cmd_binary;
          stk.alu_op = alu_and;
        end
        op_or: begin
          stk.cmd    = cmd_binary;
          stk.alu_op = alu_or;
        end
        op_equal: begin
          stk.cmd    = cmd_binary;
          stk.alu_op = alu_equal;
        end
        op_zero_equal: begin
          stk.cmd    = cmd_binary;
          stk.alu_op = alu_zero_equal;
        end
        op_io_button: begin
          stk.cmd        = cmd_replace;
          stk.push_value = word_t'({btn_sync[1], btn_sync[0]});
        end
        default: ;
      endcase
    end else if (state == st_operand && operand_ready && is_lit) begin
      // literal word is on rom_data now
      stk.cmd = cmd_push;
    end
  end

  ////////////////////
  // sequencer
  ////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      state         <= st_fetch;
      pc            <= '0;
      operand_ready <= 1'b0;
      is_lit        <= 1'b0;
      take_branch   <= 1'b0;
      tx_req        <= 1'b0;
      led_q         <= '1;
      btn_meta      <= '0;
      btn_sync      <= '0;
    end else begin
      // two flop synchronizer
      btn_meta <= {button1, button0};
      btn_sync <= btn_meta;
      case (state)
        st_fetch: state <= st_execute;
        st_execute: begin
          pc          <= pc + prog_addr_t'(1);
          state       <= st_fetch;
          is_lit      <= (op == op_lit);
          // zero branch tests the value being popped this cycle
          take_branch <= (op == op_branch) || (op == op_zero_branch && stk.tos == '0);
          case (op)
            op_lit, op_branch, op_zero_branch: begin
              state         <= st_operand;
              operand_ready <= 1'b0;
            end
            op_io_led: led_q <= ~stk.tos[led_count-1:0];
            op_emit: begin
              tx_req <= 1'b1;
              state  <= st_emit;
            end
            default: ;
          endcase
        end
        st_operand: begin
          // first cycle only presents the operand address
          if (!operand_ready) begin
            operand_ready <= 1'b1;
          end else begin
            operand_ready <= 1'b0;
            state         <= st_fetch;
            pc            <= take_branch ? prog_addr_t'(rom_data) : pc + prog_addr_t'(1);
          end
        end
        st_emit: begin
          // four phase, leave only once ack is back low
          if (tx_req && tx_ack) begin
            tx_req <= 1'b0;
          end else if (!tx_req && !tx_ack) begin
            state <= st_fetch;
          end
        end
        default: state <= st_fetch;
      endcase
    end
  end

  // low byte of the top, held while tx_req is up
  always_ff @(posedge clk) begin
    if (state == st_execute && op == op_emit) begin
      tx_byte <= stk.tos[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx import forth_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  tx_req,
  input  byte_t tx_byte,
  output logic  tx_ack,
  output logic  tx
);

  logic                   busy;
  logic [bit_timer_w-1:0] bit_timer;
  // 0 is the start bit, 1 to 8 data, 9 stop
  logic [3:0]             bit_cnt;
  // stop bit above the data, shifted out lsb first
  logic [8:0]             shreg;

  always_ff @(posedge clk) begin
    if (!reset) begin
      busy      <= 1'b0;
      bit_timer <= '0;
      bit_cnt   <= '0;
      tx_ack    <= 1'b0;
      tx        <= 1'b1;
    end else if (!busy) begin
      // ack drops once the interpreter lets go of req
      if (tx_ack && !tx_req) begin
        tx_ack <= 1'b0;
      end else if (tx_req && !tx_ack) begin
        busy      <= 1'b1;
        bit_timer <= '0;
        bit_cnt   <= '0;
        tx        <= 1'b0;
      end
    end else if (bit_timer == bit_timer_w'(clks_per_bit - 1)) begin
      bit_timer <= '0;
      if (bit_cnt == 4'd9) begin
        // end of stop bit, line already high
        busy   <= 1'b0;
        tx_ack <= 1'b1;
      end else begin
        tx      <= shreg[0];
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      bit_timer <= bit_timer + bit_timer_w'(1);
    end
  end

  ////////////////////
  // frame data
  ////////////////////

  always_ff @(posedge clk) begin
    if (!busy && tx_req && !tx_ack) begin
      shreg <= {1'b1, tx_byte};
    end else if (busy && bit_timer == bit_timer_w'(clks_per_bit - 1)) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/forth_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module forth_top import forth_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       prog_we,
  input  prog_addr_t prog_addr,
  input  word_t      prog_data,
  input  logic       button0,
  input  logic       button1,
  output logic       tx,
  output logic       led_g,
  output logic       led_b,
  output logic       led_r
);

  prog_addr_t rom_addr;
  word_t      rom_data;
  // emit handshake
  logic       tx_req;
  logic       tx_ack;
  byte_t      tx_byte;

  stack_if stk_bus ();

  ////////////////////
  // processor core
  ////////////////////

  program_ram program_ram0 (
    .clk   (clk),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .raddr (rom_addr),
    .rdata (rom_data)
  );

  inner_interpreter inner_interpreter0 (
    .clk      (clk),
    .reset    (reset),
    .stk      (stk_bus.interp),
    .rom_addr (rom_addr),
    .rom_data (rom_data),
    .button0  (button0),
    .button1  (button1),
    .led_g    (led_g),
    .led_b    (led_b),
    .led_r    (led_r),
    .tx_req   (tx_req),
    .tx_ack   (tx_ack),
    .tx_byte  (tx_byte)
  );

  data_stack data_stack0 (
    .clk   (clk),
    .reset (reset),
    .stk   (stk_bus.stack)
  );

  // serial output
  uart_tx uart_tx0 (
    .clk     (clk),
    .reset   (reset),
    .tx_req  (tx_req),
    .tx_byte (tx_byte),
    .tx_ack  (tx_ack),
    .tx      (tx)
  );

endmodule

`default_nettype wire

// ==== test/forth_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module forth_asserts (
  input logic clk,
  input logic reset,
  input logic tx_req,
  input logic tx_ack,
  input logic tx
);

  ////////////////////
  // emit handshake
  ////////////////////

  // new request only after the last ack dropped
  req_after_ack: assert property (@(posedge clk) disable iff (!reset)
    $rose(tx_req) |-> !tx_ack)
    else $error("tx_req rose while tx_ack was high");

  ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
    $rose(tx_ack) |-> tx_req)
    else $error("tx_ack rose without tx_req");

  // frame is over once ack is up
  idle_during_ack: assert property (@(posedge clk) disable iff (!reset)
    tx_ack |-> tx)
    else $error("tx low while tx_ack was high");

  ////////////////////
  // reset
  ////////////////////

  reset_values: assert property (@(posedge clk)
    !reset |=> (tx && !tx_req && !tx_ack))
    else $error("tx, tx_req or tx_ack not at reset value");

endmodule

bind forth_top forth_asserts forth_asserts0 (
  .clk    (clk),
  .reset  (reset),
  .tx_req (tx_req),
  .tx_ack (tx_ack),
  .tx     (tx)
);

`default_nettype wire

// ==== test/tb_forth.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_forth import forth_pkg::*; ();

  // clocks allowed before a start bit must show up
  localparam int start_timeout = 20000;
  // rest of the last stop bit, the handshake and a few tokens
  localparam int led_timeout   = 2 * clks_per_bit;
  localparam int vec_words     = 256;

  logic       clk;
  logic       reset;
  logic       prog_we;
  prog_addr_t prog_addr;
  word_t      prog_data;
  logic       button0;
  logic       button1;
  logic       tx;
  logic       led_g;
  logic       led_b;
  logic       led_r;

  // records of header, program words and expected bytes
  word_t vectors [vec_words];
  int    errors;
  int    tests_run;
  int    tests_failed;

  forth_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .button0   (button0),
    .button1   (button1),
    .tx        (tx),
    .led_g     (led_g),
    .led_b     (led_b),
    .led_r     (led_r)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic string test_name(input int number);
    case (number)
      2:       return "arithmetic";
      3:       return "logic and comparison";
      4:       return "stack words";
      5:       return "countdown and leds";
      6:       return "buttons";
      default: return "extra";
    endcase
  endfunction

  // line idle, all leds off
  task automatic check_idle_pins(input string phase);
    if (tx !== 1'b1) begin
      $display("mismatch at %0t: tx expected 1 got %b (%s)", $time, tx, phase);
      errors++;
    end
    if ({led_r, led_b, led_g} !== 3'b111) begin
      $display("mismatch at %0t: {led_r,led_b,led_g} expected 111 got %b (%s)",
               $time, {led_r, led_b, led_g}, phase);
      errors++;
    end
  endtask

  // program goes in while reset is low, then 5 more reset cycles
  task automatic load_program(input int base, input int count, input word_t buttons);
    @(negedge clk);
    reset   = 1'b0;
    button0 = buttons[0];
    button1 = buttons[1];
    for (int i = 0; i < count; i++) begin
      prog_we   = 1'b1;
      prog_addr = prog_addr_t'(i);
      prog_data = vectors[base + i];
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b1;
  endtask

  // serial decoder, samples mid bit
  task automatic receive_byte(output byte_t value, output logic ok);
    int waited;
    waited = 0;
    value  = '0;
    ok     = 1'b0;
    while (tx !== 1'b0 && waited < start_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0) begin
      $display("no start bit on tx within %0d clocks at %0t", waited, $time);
      errors++;
    end else begin
      repeat (clks_per_bit / 2) @(negedge clk);
      if (tx !== 1'b0) begin
        $display("start bit on tx ended early at %0t", $time);
        errors++;
      end
      // lsb first
      for (int b = 0; b < 8; b++) begin
        repeat (clks_per_bit) @(negedge clk);
        value[b] = tx;
      end
      repeat (clks_per_bit) @(negedge clk);
      if (tx !== 1'b1) begin
        $display("stop bit on tx was low at %0t", $time);
        errors++;
      end else begin
        ok = 1'b1;
      end
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic check_reset_state();
    int errors_before;
    errors_before = errors;
    @(negedge clk);
    reset = 1'b0;
    repeat (5) @(negedge clk);
    check_idle_pins("in reset");
    reset = 1'b1;
    // first cycle after release is a fetch, nothing executed yet
    @(negedge clk);
    check_idle_pins("after release");
    tests_run++;
    if (errors == errors_before) begin
      $display("test 1 reset state: pass");
    end else begin
      $display("test 1 reset state: FAIL");
      tests_failed++;
    end
  endtask

  task automatic run_test(inout int pos, input int number);
    int         prog_words;
    int         byte_count;
    int         prog_base;
    int         errors_before;
    int         waited;
    word_t      buttons;
    logic [2:0] led_expect;
    byte_t      got;
    byte_t      expect_byte;
    logic       ok;
    prog_words    = int'(vectors[pos]);
    buttons       = vectors[pos + 1];
    byte_count    = int'(vectors[pos + 2]);
    led_expect    = vectors[pos + 3][2:0];
    prog_base     = pos + 4;
    pos           = prog_base + prog_words + byte_count;
    errors_before = errors;
    load_program(prog_base, prog_words, buttons);
    ok = 1'b1;
    for (int k = 0; k < byte_count && ok; k++) begin
      expect_byte = byte_t'(vectors[prog_base + prog_words + k]);
      receive_byte(got, ok);
      if (ok && got !== expect_byte) begin
        $display("mismatch at %0t: tx byte %0d expected %02h got %02h",
                 $time, k, expect_byte, got);
        errors++;
      end
    end
    // led store can trail the last emit by a few tokens
    waited = 0;
    while ({led_r, led_b, led_g} !== led_expect && waited < led_timeout) begin
      @(negedge clk);
      waited++;
    end
    if ({led_r, led_b, led_g} !== led_expect) begin
      $display("mismatch at %0t: {led_r,led_b,led_g} expected %b got %b",
               $time, led_expect, {led_r, led_b, led_g});
      errors++;
    end
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: pass", number, test_name(number));
    end else begin
      $display("test %0d %s: FAIL", number, test_name(number));
      tests_failed++;
    end
  endtask

  initial begin
    int pos;
    int number;
    reset        = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    button0      = 1'b0;
    button1      = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    $readmemh("test/forth_vectors.txt", vectors);
    check_reset_state();
    pos    = 0;
    number = 2;
    // zero word count marks the end
    while (pos + 4 <= vec_words && vectors[pos] != '0) begin
      run_test(pos, number);
      number++;
    end
    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (errors == 0 && tests_failed == 0 && tests_run == 6) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/forth_vectors.txt ====
// per test: program words, buttons {button1,button0}, emitted bytes, leds {r,b,g}
// then the program, then the expected bytes; a record with no words ends the file
// arithmetic
e 0 2 7
1 7 1 5 6 f 1 41 1 1 5 f b c
2 42
// logic and comparison
22 0 6 7
1 c 1 a 7 f 1 c 1 a 8 f
1 33 1 33 9 f 1 33 1 34 9 f
1 0 a f 1 5 a f b 20
8 e ff 0 ff 0
// stack words
15 0 6 7
1 1 1 2 4 f f f 1 3 2 f f 1 4 1 5 3 f b 13
1 2 1 3 3 4
// countdown and leds
11 0 3 2
1 3 1 1 6 2 f 2 a c 2 3 1 5 d b f
2 1 0
// buttons
6 2 1 7
1 0 e f b 4
2
0 0 0 0

// ==== sources.f ====
rtl/forth_pkg.sv
rtl/stack_if.sv
rtl/program_ram.sv
rtl/data_stack.sv
rtl/inner_interpreter.sv
rtl/uart_tx.sv
rtl/forth_top.sv
test/forth_asserts.sv
test/tb_forth.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the forth processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_forth -f sources.f -o tb_forth; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_forth)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
